//--- rtl/victim_pkg.sv
// victim cache shared definitions
// line and address widths, way count, request and way-update
// structs, controller state encoding
`default_nettype none

package victim_pkg;

   // ####################
   // widths
   localparam int ADDR_W   = 16;  // line address, whole address is the tag
   localparam int LINE_W   = 32;  // one line of data
   localparam int NUM_WAYS = 4;
   localparam int WAY_W    = 2;   // way index

   // ####################
   // port structs

   // L2 side request, held until mem_resp
   typedef struct packed {
      logic              read;
      logic              write;
      logic [ADDR_W-1:0] addr;
      logic [LINE_W-1:0] wdata;
   } l2_req_t;  // 50 bits

   // memory side request, held until pmem_resp
   typedef struct packed {
      logic              read;
      logic              write;
      logic [ADDR_W-1:0] addr;
      logic [LINE_W-1:0] wdata;
   } pmem_req_t;  // 50 bits

   // single update port into the way storage
   typedef struct packed {
      logic             strobe;  // write this cycle
      logic [WAY_W-1:0] way;
      logic             valid;   // new valid flag
      logic             dirty;   // new dirty flag
      logic             load;    // also take tag and data from the l2 request
   } way_upd_t;  // 6 bits

   // controller states
   typedef enum logic [2:0] {
      READY,     // serve hits and writes, pick next action
      FETCH,     // read-through of a miss
      EVICT_WB,  // write back dirty recipient before a write
      IDLE_WB,   // background write-back of oldest dirty line
      CLEAN      // clear dirty flag of the line just written back
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/victim_ways.sv
// victim cache way storage
// four fully associative entries of tag, data, valid and dirty.
// compares the request address against all valid tags for the
// hit vector and returns the hit way's data; one update port
`timescale 1ns/1ns
`default_nettype none

module victim_ways (
   input  logic                                 clk,
   input  logic                                 rst,
   input  victim_pkg::l2_req_t                  req,
   input  victim_pkg::way_upd_t                 upd,
   input  logic [victim_pkg::WAY_W-1:0]         sel_way,   // write-back read select
   output logic [victim_pkg::NUM_WAYS-1:0]      hit,       // one-hot
   output logic [victim_pkg::NUM_WAYS-1:0]      valid,
   output logic [victim_pkg::NUM_WAYS-1:0]      dirty,
   output logic [victim_pkg::ADDR_W-1:0]        sel_tag,
   output logic [victim_pkg::LINE_W-1:0]        sel_data,
   output logic [victim_pkg::LINE_W-1:0]        hit_data
);

   logic [victim_pkg::ADDR_W-1:0] tag_q  [victim_pkg::NUM_WAYS];  // tag store
   logic [victim_pkg::LINE_W-1:0] data_q [victim_pkg::NUM_WAYS];  // line store

   // ####################
   // flags
   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= '0;  // all ways empty
         dirty <= '0;
      end else if (upd.strobe) begin
         valid[upd.way] <= upd.valid;
         dirty[upd.way] <= upd.dirty;
      end
   end

   // ####################
   // tag and data, only on a load update
   always_ff @(posedge clk) begin
      if (upd.strobe && upd.load) begin
         tag_q[upd.way]  <= req.addr;   // line address from the l2 eviction
         data_q[upd.way] <= req.wdata;
      end
   end

   // hit detection, tags are never duplicated so at most one bit is set
   always_comb begin
      hit_data = '0;
      for (int i = 0; i < victim_pkg::NUM_WAYS; i++) begin
         hit[i] = valid[i] && (tag_q[i] == req.addr);
         if (hit[i]) begin
            hit_data = hit_data | data_q[i];  // or-mux over the hit way
         end
      end
   end

   // selected way for write-back
   assign sel_tag  = tag_q[sel_way];
   assign sel_data = data_q[sel_way];

endmodule

`default_nettype wire

//--- rtl/victim_lru.sv
// victim cache age ranking
// one age rank per way, rank all ones is the oldest.
// a touch makes the way youngest and ages every way that was
// younger than it. reports the oldest way and the oldest dirty way
`timescale 1ns/1ns
`default_nettype none

module victim_lru (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            touch,
   input  logic [victim_pkg::WAY_W-1:0]    touch_way,
   input  logic [victim_pkg::NUM_WAYS-1:0] dirty,
   output logic [victim_pkg::WAY_W-1:0]    lru_way,
   output logic [victim_pkg::WAY_W-1:0]    oldest_dirty_way
);

   logic [victim_pkg::WAY_W-1:0] rank_q [victim_pkg::NUM_WAYS];  // 0 youngest
   logic [victim_pkg::WAY_W-1:0] best_rank;  // scan state for oldest dirty
   logic                         any_dirty;

   // rank update
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < victim_pkg::NUM_WAYS; i++) begin
            rank_q[i] <= ~i[victim_pkg::WAY_W-1:0];  // way 0 oldest .. way 3 youngest
         end
      end else if (touch) begin
         for (int i = 0; i < victim_pkg::NUM_WAYS; i++) begin
            if (i[victim_pkg::WAY_W-1:0] == touch_way) begin
               rank_q[i] <= '0;                      // now youngest
            end else if (rank_q[i] < rank_q[touch_way]) begin
               rank_q[i] <= rank_q[i] + 1'b1;        // one step older
            end
         end
      end
   end

   // ####################
   // reports
   always_comb begin
      lru_way = '0;
      for (int i = 0; i < victim_pkg::NUM_WAYS; i++) begin
         if (rank_q[i] == '1) lru_way = i[victim_pkg::WAY_W-1:0];
      end
   end

   always_comb begin
      oldest_dirty_way = lru_way;  // don't care when nothing is dirty
      best_rank        = '0;
      any_dirty        = 1'b0;
      for (int i = 0; i < victim_pkg::NUM_WAYS; i++) begin
         if (dirty[i] && (!any_dirty || rank_q[i] > best_rank)) begin
            any_dirty        = 1'b1;
            best_rank        = rank_q[i];
            oldest_dirty_way = i[victim_pkg::WAY_W-1:0];
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/victim_control.sv
// victim cache controller
// answers read hits and writes, reads misses through from memory,
// writes back a dirty recipient before overwriting it, and writes
// back the oldest dirty line when idle. a write sets a hold that
// keeps idle write-back off until the following read is served
`timescale 1ns/1ns
`default_nettype none

module victim_control (
   input  logic                            clk,
   input  logic                            rst,
   input  victim_pkg::l2_req_t             req,
   input  logic [victim_pkg::NUM_WAYS-1:0] hit,
   input  logic [victim_pkg::NUM_WAYS-1:0] valid,
   input  logic [victim_pkg::NUM_WAYS-1:0] dirty,
   input  logic [victim_pkg::WAY_W-1:0]    lru_way,
   input  logic [victim_pkg::WAY_W-1:0]    oldest_dirty_way,
   input  logic [victim_pkg::ADDR_W-1:0]   sel_tag,
   input  logic [victim_pkg::LINE_W-1:0]   sel_data,
   input  logic [victim_pkg::LINE_W-1:0]   hit_data,
   input  logic                            pmem_resp,
   input  logic [victim_pkg::LINE_W-1:0]   pmem_rdata,
   output victim_pkg::way_upd_t            upd,
   output logic [victim_pkg::WAY_W-1:0]    sel_way,
   output logic                            touch,
   output logic [victim_pkg::WAY_W-1:0]    touch_way,
   output logic                            mem_resp,
   output logic [victim_pkg::LINE_W-1:0]   mem_rdata,
   output victim_pkg::pmem_req_t           pmem_req
);

   victim_pkg::ctrl_state_t      state_q, state_d;
   logic [victim_pkg::WAY_W-1:0] hit_way;       // encoded hit vector
   logic [victim_pkg::WAY_W-1:0] recipient;     // target way of an l2 write
   logic [victim_pkg::WAY_W-1:0] wb_way_q;      // latched idle write-back way
   logic                         from_evict_q;  // CLEAN origin, 1 = EVICT_WB
   logic                         hold_q;        // read expected, no idle write-back
   logic                         any_hit;
   logic                         read_hit;
   logic                         write_ok;      // write can go in without write-back
   logic                         serve;         // state answers hits and writes

   assign any_hit  = |hit;
   assign read_hit = req.read && any_hit;
   assign write_ok = req.write && !dirty[recipient];
   assign serve    = (state_q == victim_pkg::READY) || (state_q == victim_pkg::IDLE_WB);

   always_comb begin
      hit_way = '0;
      for (int i = 0; i < victim_pkg::NUM_WAYS; i++) begin
         if (hit[i]) hit_way = i[victim_pkg::WAY_W-1:0];
      end
   end

   // ####################
   // recipient: first invalid way, else least recently used.
   // a write to a line already held reuses its way so tags stay unique
   always_comb begin
      recipient = lru_way;
      for (int i = victim_pkg::NUM_WAYS - 1; i >= 0; i--) begin
         if (!valid[i]) recipient = i[victim_pkg::WAY_W-1:0];  // lowest invalid wins
      end
      if (req.write && any_hit) recipient = hit_way;
   end

   // ####################
   // next state and outputs
   always_comb begin
      state_d        = state_q;
      upd            = '0;
      touch          = 1'b0;
      mem_resp       = 1'b0;
      mem_rdata      = hit_data;
      pmem_req       = '0;
      pmem_req.addr  = req.addr;
      pmem_req.wdata = sel_data;
      sel_way        = recipient;

      case (state_q)
         victim_pkg::READY: begin
            if (read_hit) begin
               // l2 takes the line back, nothing left to write back
               upd = '{strobe: 1'b1, way: hit_way, valid: 1'b1, dirty: 1'b0, load: 1'b0};
            end else if (req.read) begin
               state_d = victim_pkg::FETCH;     // miss, read through
            end else if (req.write && !write_ok) begin
               state_d = victim_pkg::EVICT_WB;  // recipient still dirty
            end else if (!req.write && !hold_q && (|dirty)) begin
               state_d = victim_pkg::IDLE_WB;
            end
         end
         victim_pkg::FETCH: begin
            pmem_req.read = 1'b1;
            mem_resp      = pmem_resp;   // pass the memory answer straight up
            mem_rdata     = pmem_rdata;
            if (pmem_resp) state_d = victim_pkg::READY;
         end
         victim_pkg::EVICT_WB: begin
            pmem_req.write = 1'b1;
            pmem_req.addr  = sel_tag;    // line of the recipient
            if (pmem_resp) state_d = victim_pkg::CLEAN;
         end
         victim_pkg::IDLE_WB: begin
            sel_way        = wb_way_q;
            pmem_req.write = 1'b1;
            pmem_req.addr  = sel_tag;
            if (pmem_resp) state_d = victim_pkg::CLEAN;
         end
         victim_pkg::CLEAN: begin
            sel_way = from_evict_q ? recipient : wb_way_q;
            upd     = '{strobe: 1'b1, way: sel_way, valid: 1'b1, dirty: 1'b0, load: 1'b0};
            state_d = victim_pkg::READY;
         end
         default: state_d = victim_pkg::READY;
      endcase

      // hits and non-blocked writes in READY and IDLE_WB
      if (serve && (read_hit || write_ok)) begin
         mem_resp = 1'b1;
         touch    = 1'b1;
      end
      if (serve && write_ok) begin
         upd = '{strobe: 1'b1, way: recipient, valid: 1'b1, dirty: 1'b1, load: 1'b1};
      end
   end

   assign touch_way = read_hit ? hit_way : recipient;

   // ####################
   // state, origin bit and hold
   always_ff @(posedge clk) begin
      if (rst) begin
         state_q      <= victim_pkg::READY;
         from_evict_q <= 1'b0;
         hold_q       <= 1'b0;
      end else begin
         state_q <= state_d;
         if (state_d == victim_pkg::CLEAN) begin
            from_evict_q <= (state_q == victim_pkg::EVICT_WB);
         end
         if (mem_resp && req.write) hold_q <= 1'b1;      // eviction from l2, read follows
         else if (mem_resp && req.read) hold_q <= 1'b0;  // hit or read-through done
      end
   end

   // way for idle write-back, fixed for the whole sequence
   always_ff @(posedge clk) begin
      if (state_q == victim_pkg::READY && state_d == victim_pkg::IDLE_WB) begin
         wb_way_q <= oldest_dirty_way;
      end
   end

endmodule

`default_nettype wire

//--- rtl/victim_cache.sv
// victim cache top level
// four-way fully associative victim cache between an L2 cache and
// physical memory. connects way storage, age ranking and control
`timescale 1ns/1ns
`default_nettype none

module victim_cache (
   input  logic                          clk,
   input  logic                          rst,
   input  victim_pkg::l2_req_t           req,
   output logic                          mem_resp,
   output logic [victim_pkg::LINE_W-1:0] mem_rdata,
   output victim_pkg::pmem_req_t         pmem_req,
   input  logic                          pmem_resp,
   input  logic [victim_pkg::LINE_W-1:0] pmem_rdata
);

   victim_pkg::way_upd_t            upd;
   logic [victim_pkg::WAY_W-1:0]    sel_way;
   logic [victim_pkg::NUM_WAYS-1:0] hit;
   logic [victim_pkg::NUM_WAYS-1:0] valid;
   logic [victim_pkg::NUM_WAYS-1:0] dirty;
   logic [victim_pkg::ADDR_W-1:0]   sel_tag;
   logic [victim_pkg::LINE_W-1:0]   sel_data;
   logic [victim_pkg::LINE_W-1:0]   hit_data;
   logic                            touch;
   logic [victim_pkg::WAY_W-1:0]    touch_way;
   logic [victim_pkg::WAY_W-1:0]    lru_way;
   logic [victim_pkg::WAY_W-1:0]    oldest_dirty_way;

   // ####################
   // storage
   victim_ways ways (
      .clk, .rst, .req, .upd, .sel_way,
      .hit, .valid, .dirty, .sel_tag, .sel_data, .hit_data
   );

   // age ranking
   victim_lru lru (
      .clk, .rst, .touch, .touch_way, .dirty,
      .lru_way, .oldest_dirty_way
   );

   // ####################
   // controller
   victim_control control (
      .clk, .rst, .req, .hit, .valid, .dirty, .lru_way, .oldest_dirty_way,
      .sel_tag, .sel_data, .hit_data, .pmem_resp, .pmem_rdata,
      .upd, .sel_way, .touch, .touch_way, .mem_resp, .mem_rdata, .pmem_req
   );

endmodule

`default_nettype wire

//--- include/victim_model.svh
// victim cache reference model
// mirrors the four ways with their flags, the age order used to pick
// a recipient, and the backing memory behind the cache
`ifndef VICTIM_MODEL_SVH
`define VICTIM_MODEL_SVH

logic [victim_pkg::ADDR_W-1:0] held_tag   [victim_pkg::NUM_WAYS];
logic [victim_pkg::LINE_W-1:0] held_data  [victim_pkg::NUM_WAYS];
logic                          held_valid [victim_pkg::NUM_WAYS];
logic                          held_dirty [victim_pkg::NUM_WAYS];
int                            age_order  [$];  // front is least recently used
logic [victim_pkg::LINE_W-1:0] backing    [logic [victim_pkg::ADDR_W-1:0]];  // written lines

// unwritten memory, every address bit reaches the pattern
function automatic logic [victim_pkg::LINE_W-1:0] fill_value(
   input logic [victim_pkg::ADDR_W-1:0] addr);
   return {addr ^ 16'hc3a5, addr * 16'h0b1d};
endfunction

function automatic logic [victim_pkg::LINE_W-1:0] backing_read(
   input logic [victim_pkg::ADDR_W-1:0] addr);
   return backing.exists(addr) ? backing[addr] : fill_value(addr);
endfunction

task automatic model_reset();
   for (int i = 0; i < victim_pkg::NUM_WAYS; i++) begin
      held_valid[i] = 1'b0;
      held_dirty[i] = 1'b0;
   end
   age_order = {0, 1, 2, 3};  // way 0 oldest after reset
endtask

// way holding addr, -1 when not held
function automatic int find_way(input logic [victim_pkg::ADDR_W-1:0] addr);
   for (int i = 0; i < victim_pkg::NUM_WAYS; i++) begin
      if (held_valid[i] && held_tag[i] == addr) return i;
   end
   return -1;
endfunction

function automatic int pick_recipient();
   for (int i = 0; i < victim_pkg::NUM_WAYS; i++) begin
      if (!held_valid[i]) return i;  // first empty way
   end
   return age_order[0];
endfunction

task automatic make_youngest(input int w);
   for (int i = 0; i < age_order.size(); i++) begin
      if (age_order[i] == w) begin
         age_order.delete(i);
         break;
      end
   end
   age_order.push_back(w);
endtask

`endif

//--- verification/tb_victim_cache.sv
// victim cache testbench
// random L2 reads and writes over a small line pool, a memory with
// random latency, every response checked against a reference model
`timescale 1ns/1ns
`default_nettype none

module tb_victim_cache;

   localparam int SEED       = 26604;
   localparam int PERIOD     = 40;
   localparam int RST_CYCLES = 16;
   localparam int NUM_TXN    = 400;
   localparam int MAX_CYCLES = NUM_TXN * 40 + 2 * RST_CYCLES;  // 40 cycles per transaction
   localparam int POOL       = 8;  // line addresses in use, twice the way count

   logic                          clk;
   logic                          rst;
   victim_pkg::l2_req_t           req;
   logic                          mem_resp;
   logic [victim_pkg::LINE_W-1:0] mem_rdata;
   victim_pkg::pmem_req_t         pmem_req;
   logic                          pmem_resp;
   logic [victim_pkg::LINE_W-1:0] pmem_rdata;
   victim_pkg::pmem_req_t         pmem_seen;  // memory request at the last falling edge
   int                            wait_left;  // cycles until the memory answers
   int                            cycles;
   logic                          fetched;    // memory read seen for the current read
   logic                          after_wb;   // last cycle ended a memory write

   `include "victim_model.svh"

   victim_cache UUT (
      .clk, .rst, .req, .mem_resp, .mem_rdata, .pmem_req, .pmem_resp, .pmem_rdata
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // ####################
   // checks
   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp) else
         stop_run($sformatf("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp));
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond) else stop_run(what);
   endtask

   function automatic logic [victim_pkg::ADDR_W-1:0] line_address(input int idx);
      return 16'h3a40 + 16'h0104 * idx[15:0];  // spread over the address space
   endfunction

   task automatic next_request();
      int idx;
      idx       = $urandom % POOL;
      req.read  = (($urandom & 1) == 0);
      req.write = !req.read;
      req.addr  = line_address(idx);
      req.wdata = $urandom;
   endtask

   // write-back must carry a dirty held line, memory takes it over
   task automatic write_back_seen();
      int w;
      w = find_way(pmem_req.addr);
      check_true(w >= 0 && held_dirty[w],
                 $sformatf("write-back of line %0h that is not dirty in the cache", pmem_req.addr));
      check_value("pmem_req.wdata", pmem_req.wdata, held_data[w]);
      backing[pmem_req.addr] = pmem_req.wdata;
      held_dirty[w]          = 1'b0;
   endtask

   task automatic read_done(input int w);
      if (w >= 0) begin
         check_value("mem_rdata", mem_rdata, held_data[w]);
         if (!pmem_req.write) held_dirty[w] = 1'b0;  // ready state, L2 takes the line back
         make_youngest(w);
      end else begin
         check_true(fetched, "read miss answered without a memory read");
         check_value("mem_rdata", mem_rdata, backing_read(req.addr));
      end
   endtask

   task automatic write_done(input int w);
      int r;
      r = (w >= 0) ? w : pick_recipient();  // a held line keeps its way
      check_true(!held_dirty[r], "write accepted over a dirty line that was not written back");
      held_tag[r]   = req.addr;
      held_data[r]  = req.wdata;
      held_valid[r] = 1'b1;
      held_dirty[r] = 1'b1;
      make_youngest(r);
   endtask

   // one cycle of bus activity, the model moves with the coming edge
   task automatic observe_cycle();
      int w;
      w = find_way(req.addr);
      check_true(!(pmem_req.read && pmem_req.write), "memory read and write requested together");
      if (req.read && w >= 0) check_true(!pmem_req.read, "memory read for a line held in the cache");
      if (req.read && w >= 0 && !after_wb) begin  // only the clean step delays a hit
         check_true(mem_resp, "read hit not answered in the request cycle");
      end
      if (pmem_resp && pmem_req.read) begin
         check_value("pmem_req.addr", pmem_req.addr, req.addr);
         fetched = 1'b1;
      end
      if (pmem_resp && pmem_req.write) write_back_seen();
      if (mem_resp && req.read) read_done(w);
      else if (mem_resp && req.write) write_done(w);
      else check_true(!mem_resp, "mem_resp raised with no request pending");
      if (mem_resp) fetched = 1'b0;
      after_wb = pmem_resp && pmem_req.write;  // next cycle is the clean step
   endtask

   always @(negedge clk) begin
      pmem_seen = pmem_req;
      if (!rst) observe_cycle();
   end

   // ####################
   // memory, answers a held request after 1 to 4 cycles
   always @(posedge clk) begin
      #2;
      if (pmem_resp) begin
         pmem_resp = 1'b0;  // one cycle only
      end else if (pmem_seen.read || pmem_seen.write) begin
         if (wait_left == 0) wait_left = 1 + ($urandom % 4);
         wait_left = wait_left - 1;
         if (wait_left == 0) begin
            pmem_resp  = 1'b1;
            pmem_rdata = backing_read(pmem_seen.addr);
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES) stop_run("timeout, the cache stopped answering requests");
   end

   // ####################
   // stimulus
   initial begin
      int gap;
      void'($urandom(SEED));
      rst        = 1'b1;
      req        = '0;
      pmem_resp  = 1'b0;
      pmem_rdata = '0;
      pmem_seen  = '0;
      wait_left  = 0;
      cycles     = 0;
      fetched    = 1'b0;
      after_wb   = 1'b0;
      model_reset();
      repeat (RST_CYCLES) @(posedge clk);
      #2 rst = 1'b0;
      repeat (RST_CYCLES) begin  // quiet while nothing is requested
         @(negedge clk);
         check_value("mem_resp", mem_resp, 1'b0);
         check_value("pmem_req.read", pmem_req.read, 1'b0);
         check_value("pmem_req.write", pmem_req.write, 1'b0);
      end
      for (int n = 0; n < NUM_TXN; n++) begin
         gap = $urandom % 4;  // idle cycles open the way for idle write-back
         repeat (gap) begin
            @(posedge clk);
            #2 req = '0;
         end
         @(posedge clk);
         #2 next_request();
         @(negedge clk);
         while (!mem_resp) @(negedge clk);
      end
      @(posedge clk);
      #2 req = '0;
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- victim_cache.f
+incdir+include
rtl/victim_pkg.sv
rtl/victim_ways.sv
rtl/victim_lru.sv
rtl/victim_control.sv
rtl/victim_cache.sv
verification/tb_victim_cache.sv

//--- Makefile
# Verilator build and run of the victim cache testbench
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -Wno-fatal -j 0
TOP       ?= tb_victim_cache
FILELIST  ?= victim_cache.f
PASS_TEXT := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir
